// File: verilog/ice_cfg.svh
`ifndef ICE_CFG_SVH
`define ICE_CFG_SVH

// Number of loopback devices hanging off the master bus
`define ICE_NUM_DEV 4

// Address of device 0, device i answers to base plus i
`define ICE_DEV_BASE 8'h10

// Ring buffer slot address width, 32 entries per device
`define ICE_SLOT_W 5

// Credits the transmit side owns after reset
`define ICE_TX_CREDITS 4

// Width of the credit counter
`define ICE_CREDIT_W 3

`endif

// File: verilog/ice_pkg.sv
`default_nettype none
`include "ice_cfg.svh"

package ice_pkg;

	typedef logic [7:0] ice_char_t;

	// Bit 8 flags the last entry of a stored response
	typedef logic [8:0] ice_entry_t;

	typedef logic [`ICE_SLOT_W-1:0] ice_slot_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_ID,
		RX_LEN,
		RX_PYLD,
		RX_DISCARD
	} ice_rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SCAN,
		TX_HEADER,
		TX_LEN,
		TX_PAYLOAD
	} ice_tx_state_t;

	typedef struct packed {
		logic      valid;
		ice_char_t data;
	} ice_link_t;

	typedef struct packed {
		logic      frame_valid;
		logic      data_valid;
		ice_char_t addr;
		ice_char_t data;
	} ice_ma_bus_t;

	typedef struct packed {
		ice_slot_t  tail;
		ice_entry_t data;
	} ice_sl_rsp_t;

	typedef struct packed {
		logic      valid;
		ice_char_t evt_id;
	} ice_nak_t;

endpackage

`default_nettype wire

// File: verilog/ice_bus_controller.sv
`default_nettype none
`include "ice_cfg.svh"

module ice_bus_controller (
	input  wire                        clk,
	input  wire                        rst,
	input  wire ice_pkg::ice_link_t    rx,
	input  wire                        tx_credit,
	output ice_pkg::ice_link_t         tx,
	output ice_pkg::ice_nak_t          nak,
	output ice_pkg::ice_ma_bus_t       ma_bus,
	input  wire                        sl_ovf_any,
	input  wire                        granted,
	input  wire ice_pkg::ice_sl_rsp_t  sl_rsp,
	output ice_pkg::ice_slot_t         sl_addr,
	output logic                       sl_release
);
	import ice_pkg::*;

	ice_rx_state_t rx_state;
	ice_rx_state_t rx_next;
	ice_char_t     addr_q;
	ice_char_t     evt_id;
	ice_char_t     pyld_len;
	ice_char_t     pyld_cnt;
	logic          pyld_done;
	logic          take_addr;
	logic          take_id;
	logic          take_len;
	logic          cnt_clr;
	logic          cnt_inc;

	ice_tx_state_t            tx_state;
	ice_tx_state_t            tx_next;
	ice_slot_t                rd_off;
	ice_slot_t                last_off;
	logic [`ICE_CREDIT_W-1:0] credit;
	logic                     have_credit;
	logic                     off_clr;
	logic                     off_inc;
	logic                     save_last;

	// All payload characters of the current frame are in
	assign pyld_done = (pyld_cnt == pyld_len);

	always_comb begin
		rx_next = rx_state;
		take_addr = 1'b0;
		take_id = 1'b0;
		take_len = 1'b0;
		cnt_clr = 1'b0;
		cnt_inc = 1'b0;
		ma_bus.frame_valid = 1'b0;
		ma_bus.data_valid = 1'b0;
		ma_bus.addr = addr_q;
		ma_bus.data = rx.data;
		nak.valid = 1'b0;
		nak.evt_id = evt_id;

		case (rx_state)
			RX_IDLE: begin
				take_addr = rx.valid;
				if (rx.valid)
					rx_next = RX_ID;
			end

			RX_ID: begin
				ma_bus.frame_valid = 1'b1;
				ma_bus.data_valid = rx.valid;
				take_id = rx.valid;
				if (rx.valid)
					rx_next = RX_LEN;
			end

			RX_LEN: begin
				ma_bus.frame_valid = 1'b1;
				ma_bus.data_valid = rx.valid;
				take_len = rx.valid;
				cnt_clr = rx.valid;
				if (rx.valid)
					rx_next = RX_PYLD;
			end

			// Overflow wins over the end of frame, so a short frame still NAKs
			RX_PYLD: begin
				if (sl_ovf_any) begin
					nak.valid = 1'b1;
					if (pyld_done) begin
						take_addr = rx.valid;
						rx_next = rx.valid ? RX_ID : RX_IDLE;
					end else begin
						cnt_inc = rx.valid;
						rx_next = RX_DISCARD;
					end
				end else if (pyld_done) begin
					// A new address may follow the last payload directly
					take_addr = rx.valid;
					rx_next = rx.valid ? RX_ID : RX_IDLE;
				end else begin
					ma_bus.frame_valid = 1'b1;
					ma_bus.data_valid = rx.valid;
					cnt_inc = rx.valid;
				end
			end

			// Swallow the rest of a dropped frame
			RX_DISCARD: begin
				if (pyld_done) begin
					take_addr = rx.valid;
					rx_next = rx.valid ? RX_ID : RX_IDLE;
				end else begin
					cnt_inc = rx.valid;
				end
			end

			default: rx_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (take_addr)
			addr_q <= rx.data;
		if (take_id)
			evt_id <= rx.data;
		if (take_len)
			pyld_len <= rx.data;

		if (rst) begin
			rx_state <= RX_IDLE;
			pyld_cnt <= '0;
		end else begin
			rx_state <= rx_next;
			if (cnt_clr)
				pyld_cnt <= '0;
			else if (cnt_inc)
				pyld_cnt <= pyld_cnt + 1'b1;
		end
	end

	assign have_credit = (credit != '0);
	assign sl_addr = sl_rsp.tail + rd_off;

	always_comb begin
		tx_next = tx_state;
		off_clr = 1'b0;
		off_inc = 1'b0;
		save_last = 1'b0;
		sl_release = 1'b0;
		tx.valid = 1'b0;
		tx.data = sl_rsp.data[7:0];

		case (tx_state)
			TX_IDLE: begin
				off_clr = 1'b1;
				if (granted)
					tx_next = TX_SCAN;
			end

			// Walk the granted buffer up to the marked entry
			TX_SCAN: begin
				if (sl_rsp.data[8]) begin
					save_last = 1'b1;
					off_clr = 1'b1;
					tx_next = TX_HEADER;
				end else begin
					off_inc = 1'b1;
				end
			end

			// Event id then device address, an empty response stays on its last entry
			TX_HEADER: begin
				tx.valid = have_credit;
				off_inc = have_credit && (rd_off != last_off);
				if (have_credit && rd_off == ice_slot_t'(1))
					tx_next = TX_LEN;
			end

			TX_LEN: begin
				tx.valid = have_credit;
				tx.data = ice_char_t'(last_off - 1'b1);
				if (have_credit) begin
					if (last_off == ice_slot_t'(1)) begin
						sl_release = 1'b1;
						tx_next = TX_IDLE;
					end else begin
						tx_next = TX_PAYLOAD;
					end
				end
			end

			TX_PAYLOAD: begin
				tx.valid = have_credit;
				if (have_credit) begin
					if (rd_off == last_off) begin
						sl_release = 1'b1;
						tx_next = TX_IDLE;
					end else begin
						off_inc = 1'b1;
					end
				end
			end

			default: tx_next = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (save_last)
			last_off <= rd_off;

		if (rst) begin
			tx_state <= TX_IDLE;
			rd_off <= '0;
			credit <= `ICE_CREDIT_W'(`ICE_TX_CREDITS);
		end else begin
			tx_state <= tx_next;
			if (off_clr)
				rd_off <= '0;
			else if (off_inc)
				rd_off <= rd_off + 1'b1;

			case ({tx_credit, tx.valid})
				2'b10: credit <= credit + 1'b1;
				2'b01: credit <= credit - 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	// The link never hands back more credits than it was given
	assert property (@(posedge clk) disable iff (rst)
		credit <= `ICE_CREDIT_W'(`ICE_TX_CREDITS));

	assert property (@(posedge clk) disable iff (rst)
		tx.valid |-> credit != '0);

endmodule

`default_nettype wire

// File: verilog/ice_bus_device.sv
`default_nettype none
`include "ice_cfg.svh"

module ice_bus_device #(
	parameter ice_pkg::ice_char_t DEV_ADDR = 8'h10
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire ice_pkg::ice_ma_bus_t  ma_bus,
	input  wire ice_pkg::ice_slot_t    sl_addr,
	input  wire                        sl_release,
	input  wire                        sl_grant,
	output logic                       sl_req,
	output logic                       sl_ovf,
	output ice_pkg::ice_sl_rsp_t       sl_rsp
);
	import ice_pkg::*;

	ice_entry_t mem [2**`ICE_SLOT_W];
	ice_slot_t  head;
	ice_slot_t  tail;
	ice_slot_t  wptr;
	ice_slot_t  free_slots;
	ice_slot_t  wr_addr;
	ice_entry_t wr_data;
	ice_char_t  left;
	logic       got_id;
	logic       got_len;
	logic       match;
	logic       accept;
	logic       fits;
	logic       wr_en;

	// One slot always stays empty so head equal to tail means no data
	assign free_slots = tail - head - 1'b1;
	assign fits = 9'(free_slots) >= 9'(ma_bus.data) + 9'd2;

	always_comb begin
		wr_en = 1'b0;
		wr_addr = wptr;
		wr_data = {1'b0, ma_bus.data};
		if (ma_bus.data_valid) begin
			if (!got_id) begin
				// Slot at wptr is free, so the id may land before acceptance
				wr_en = (ma_bus.addr == DEV_ADDR);
			end else if (!got_len) begin
				wr_en = match && fits;
				wr_addr = wptr + 1'b1;
				wr_data = {(ma_bus.data == '0), DEV_ADDR};
			end else begin
				wr_en = accept && (left != '0);
				wr_data = {(left == 8'd1), ma_bus.data};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (ma_bus.data_valid && got_id && !got_len)
			left <= ma_bus.data;
		else if (wr_en && got_len)
			left <= left - 1'b1;

		if (rst) begin
			head <= '0;
			tail <= '0;
			wptr <= '0;
			got_id <= 1'b0;
			got_len <= 1'b0;
			match <= 1'b0;
			accept <= 1'b0;
			sl_ovf <= 1'b0;
		end else begin
			if (sl_release && sl_grant)
				tail <= sl_addr + 1'b1;

			if (!ma_bus.frame_valid) begin
				// Frame over, commit what was accepted
				if (accept)
					head <= wptr;
				got_id <= 1'b0;
				got_len <= 1'b0;
				match <= 1'b0;
				accept <= 1'b0;
				sl_ovf <= 1'b0;
			end else if (ma_bus.data_valid) begin
				if (!got_id) begin
					got_id <= 1'b1;
					match <= (ma_bus.addr == DEV_ADDR);
				end else if (!got_len) begin
					got_len <= 1'b1;
					if (match && fits) begin
						accept <= 1'b1;
						wptr <= wptr + 2'd2;
					end else if (match) begin
						sl_ovf <= 1'b1;
					end
				end else if (wr_en) begin
					wptr <= wptr + 1'b1;
				end
			end
		end
	end

	assign sl_req = (head != tail);
	assign sl_rsp.tail = tail;
	assign sl_rsp.data = mem[sl_addr];

	// Acceptance test plus concurrent drain must never let writes overrun
	assert property (@(posedge clk) disable iff (rst)
		accept |-> wptr != tail);

endmodule

`default_nettype wire

// File: verilog/ice_bus_arbiter.sv
`default_nettype none

module ice_bus_arbiter #(
	parameter int NUM_DEV = 4
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire [NUM_DEV-1:0]          sl_req,
	input  wire [NUM_DEV-1:0]          sl_ovf,
	input  wire ice_pkg::ice_sl_rsp_t  rsp_in [NUM_DEV],
	input  wire                        sl_release,
	output logic [NUM_DEV-1:0]         sl_grant,
	output logic                       granted,
	output ice_pkg::ice_sl_rsp_t       rsp_out,
	output logic                       sl_ovf_any
);

	logic [NUM_DEV-1:0] lowest;

	// Isolate the lowest set request bit
	assign lowest = sl_req & (~sl_req + 1'b1);

	always_ff @(posedge clk) begin
		if (rst)
			sl_grant <= '0;
		else if (sl_release)
			sl_grant <= '0;
		else if (sl_grant == '0)
			sl_grant <= lowest;
	end

	assign granted = |sl_grant;
	assign sl_ovf_any = |sl_ovf;

	always_comb begin
		rsp_out = rsp_in[0];
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_grant[i])
				rsp_out = rsp_in[i];
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		$onehot0(sl_grant));

endmodule

`default_nettype wire

// File: verilog/ice_bus_top.sv
`default_nettype none
`include "ice_cfg.svh"

module ice_bus_top (
	input  wire                      clk,
	input  wire                      rst,
	input  wire ice_pkg::ice_link_t  rx,
	input  wire                      tx_credit,
	output ice_pkg::ice_link_t       tx,
	output ice_pkg::ice_nak_t        nak
);
	import ice_pkg::*;

	ice_ma_bus_t             ma_bus;
	ice_slot_t               sl_addr;
	ice_sl_rsp_t             rsp_granted;
	logic                    sl_release;
	logic                    granted;
	logic                    sl_ovf_any;
	logic [`ICE_NUM_DEV-1:0] sl_grant;
	wire [`ICE_NUM_DEV-1:0]  sl_req;
	wire [`ICE_NUM_DEV-1:0]  sl_ovf;
	wire ice_sl_rsp_t        sl_rsp [`ICE_NUM_DEV];

	ice_bus_controller ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.rx         (rx),
		.tx_credit  (tx_credit),
		.tx         (tx),
		.nak        (nak),
		.ma_bus     (ma_bus),
		.sl_ovf_any (sl_ovf_any),
		.granted    (granted),
		.sl_rsp     (rsp_granted),
		.sl_addr    (sl_addr),
		.sl_release (sl_release)
	);

	ice_bus_arbiter #(
		.NUM_DEV (`ICE_NUM_DEV)
	) arb_i (
		.clk        (clk),
		.rst        (rst),
		.sl_req     (sl_req),
		.sl_ovf     (sl_ovf),
		.rsp_in     (sl_rsp),
		.sl_release (sl_release),
		.sl_grant   (sl_grant),
		.granted    (granted),
		.rsp_out    (rsp_granted),
		.sl_ovf_any (sl_ovf_any)
	);

	for (genvar i = 0; i < `ICE_NUM_DEV; i++) begin : g_dev
		ice_bus_device #(
			.DEV_ADDR (ice_char_t'(`ICE_DEV_BASE + i))
		) dev_i (
			.clk        (clk),
			.rst        (rst),
			.ma_bus     (ma_bus),
			.sl_addr    (sl_addr),
			.sl_release (sl_release),
			.sl_grant   (sl_grant[i]),
			.sl_req     (sl_req[i]),
			.sl_ovf     (sl_ovf[i]),
			.sl_rsp     (sl_rsp[i])
		);
	end

endmodule

`default_nettype wire

// File: sim/tb_ice_bus.sv
`default_nettype none
`include "ice_cfg.svh"

module tb_ice_bus;
	import ice_pkg::*;

	localparam int CLK_HALF = 2;
	localparam int SLOTS = 2 ** `ICE_SLOT_W;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_FRAMES = 13 + 2 + 5 + NUM_RANDOM;
	localparam int MAX_FRAME_CHARS = 15;
	// Each character in and out gets 40 cycles
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_FRAME_CHARS * 2 * 40;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      tx_credit = 1'b0;
	ice_link_t rx = '0;
	ice_link_t tx;
	ice_nak_t  nak;

	logic [15:0] stim_state = 16'd1;
	logic [15:0] credit_state = 16'd1;
	int          credit_cycle = 0;
	int          credit_due [$];

	// Reference model
	ice_char_t exp_q [`ICE_NUM_DEV][$];
	ice_char_t nak_q [$];
	int        used [`ICE_NUM_DEV] = '{default: 0};
	int        waiting [`ICE_NUM_DEV] = '{default: 0};
	int        model_credit = `ICE_TX_CREDITS;
	int        frames_seen = 0;
	int        naks_seen = 0;
	ice_char_t evt_cnt = '0;
	int        rx_field = 0;
	ice_char_t cur_addr;
	ice_char_t cur_evt;
	ice_char_t cur_len;
	int        cur_cnt = 0;
	int        cur_dev = 0;
	logic      cur_accept = 1'b0;
	int        tx_idx = 0;
	ice_char_t tx_first;
	ice_char_t tx_len;
	int        tx_dev = 0;
	int        next_dev = -1;

	ice_bus_top ice_bus_top_i (
		.clk       (clk),
		.rst       (rst),
		.rx        (rx),
		.tx_credit (tx_credit),
		.tx        (tx),
		.nak       (nak)
	);

	always #CLK_HALF clk = ~clk;

	function automatic ice_char_t lfsr_take(inout logic [15:0] state, input int nbits);
		ice_char_t val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[6:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
		end
		return val;
	endfunction

	function automatic ice_char_t dev_byte(input int d);
		return ice_char_t'(int'(`ICE_DEV_BASE) + d);
	endfunction

	function automatic logic drained();
		logic empty;
		empty = (nak_q.size() == 0) && (tx_idx == 0);
		for (int i = 0; i < `ICE_NUM_DEV; i++)
			empty = empty && (exp_q[i].size() == 0);
		return empty;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_char(input string name, input ice_char_t got, input ice_char_t exp);
		assert (got == exp) else
			abort_run($sformatf("error at time %0t: %s is 0x%02h, expected 0x%02h",
				$time, name, got, exp));
	endtask

	task automatic send_char(input ice_char_t c);
		@(posedge clk);
		rx <= {1'b1, c};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			rx <= '0;
		end
	endtask

	task automatic send_frame(input ice_char_t addr, input ice_char_t len);
		send_char(addr);
		send_char(evt_cnt);
		send_char(len);
		for (int i = 0; i < int'(len); i++)
			send_char(lfsr_take(stim_state, 8));
		evt_cnt = evt_cnt + 1'b1;
	endtask

	// Polled on the falling edge, after the model has seen the rising one
	task automatic wait_drained();
		@(negedge clk);
		while (!drained())
			@(negedge clk);
	endtask

	task automatic end_frame();
		if (cur_accept)
			waiting[cur_dev]++;
		rx_field = 0;
	endtask

	// Parse the incoming frame as the device would see it
	task automatic model_rx(input ice_char_t c);
		case (rx_field)
			0: begin
				cur_addr = c;
				frames_seen++;
				rx_field = 1;
			end
			1: begin
				cur_evt = c;
				rx_field = 2;
			end
			2: begin
				cur_len = c;
				cur_cnt = 0;
				cur_accept = 1'b0;
				cur_dev = int'(cur_addr) - int'(`ICE_DEV_BASE);
				rx_field = 3;
				if (cur_dev >= 0 && cur_dev < `ICE_NUM_DEV) begin
					// A response needs id, address and payload slots
					if (SLOTS - 1 - used[cur_dev] >= int'(c) + 2) begin
						cur_accept = 1'b1;
						used[cur_dev] += int'(c) + 2;
						exp_q[cur_dev].push_back(cur_evt);
						exp_q[cur_dev].push_back(cur_addr);
						exp_q[cur_dev].push_back(c);
					end else begin
						nak_q.push_back(cur_evt);
					end
				end
				if (c == '0)
					end_frame();
			end
			default: begin
				if (cur_accept)
					exp_q[cur_dev].push_back(c);
				cur_cnt++;
				if (cur_cnt == int'(cur_len))
					end_frame();
			end
		endcase
	endtask

	task automatic check_nak(input ice_char_t evt);
		assert (nak_q.size() > 0) else
			abort_run("nak pulse seen although no frame was dropped");
		expect_char("nak.evt_id", evt, nak_q.pop_front());
		naks_seen++;
	endtask

	task automatic check_tx(input ice_char_t c, input int snap [`ICE_NUM_DEV]);
		int d;
		if (tx_idx == 0) begin
			tx_first = c;
		end else if (tx_idx == 1) begin
			d = int'(c) - int'(`ICE_DEV_BASE);
			assert (d >= 0 && d < `ICE_NUM_DEV) else
				abort_run("response address byte matches no device");
			if (next_dev >= 0)
				expect_char("tx.data address", c, dev_byte(next_dev));
			assert (waiting[d] > 0) else
				abort_run("response sent by a device holding no complete frame");
			tx_dev = d;
			expect_char("tx.data event id", tx_first, exp_q[d].pop_front());
			expect_char("tx.data address", c, exp_q[d].pop_front());
		end else if (tx_idx == 2) begin
			expect_char("tx.data length", c, exp_q[tx_dev].pop_front());
			tx_len = c;
		end else begin
			expect_char("tx.data payload", c, exp_q[tx_dev].pop_front());
		end

		if (tx_idx >= 2 && tx_idx == int'(tx_len) + 2) begin
			used[tx_dev] -= int'(tx_len) + 2;
			waiting[tx_dev]--;
			snap[tx_dev]--;
			// Lowest device that the arbiter can see waiting
			next_dev = -1;
			for (int i = `ICE_NUM_DEV - 1; i >= 0; i--)
				if (snap[i] > 0)
					next_dev = i;
			tx_idx = 0;
		end else begin
			tx_idx++;
		end
	endtask

	always @(posedge clk) begin
		int snap [`ICE_NUM_DEV];
		if (!rst) begin
			snap = waiting;
			assert (!(tx.valid || nak.valid) || frames_seen > 0) else
				abort_run("tx or nak active before any frame was sent");
			if (rx.valid)
				model_rx(rx.data);
			if (nak.valid)
				check_nak(nak.evt_id);
			if (tx.valid) begin
				assert (model_credit > 0) else
					abort_run("tx.valid high while the credit count is zero");
				check_tx(tx.data, snap);
			end
			model_credit = model_credit + int'(tx_credit) - int'(tx.valid);
		end
	end

	// Link side returns one credit per character after a random delay
	always @(posedge clk) begin
		if (rst) begin
			tx_credit <= 1'b0;
		end else begin
			credit_cycle++;
			if (tx.valid)
				credit_due.push_back(credit_cycle + 4 + int'(lfsr_take(credit_state, 4)));
			if (credit_due.size() > 0 && credit_due[0] <= credit_cycle) begin
				tx_credit <= 1'b1;
				void'(credit_due.pop_front());
			end else begin
				tx_credit <= 1'b0;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		abort_run("watchdog expired before all responses were drained");
	end

	initial begin
		ice_char_t addr;
		ice_char_t len;
		int        gap;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Every length once, each answered before the next goes out
		for (int n = 0; n <= 12; n++) begin
			send_frame(dev_byte(n % `ICE_NUM_DEV), ice_char_t'(n));
			idle_cycles(1);
			wait_drained();
		end

		// Just below and just above the device range
		send_frame(dev_byte(-1), 8'd3);
		idle_cycles(1);
		send_frame(dev_byte(`ICE_NUM_DEV), 8'd5);
		idle_cycles(1);
		wait_drained();

		// Device 1 fills faster than it drains
		repeat (4)
			send_frame(dev_byte(1), 8'd12);
		send_frame(dev_byte(2), 8'd2);
		idle_cycles(1);
		wait_drained();

		for (int n = 0; n < NUM_RANDOM; n++) begin
			addr = ice_char_t'(int'(`ICE_DEV_BASE) - 2 + int'(lfsr_take(stim_state, 3)));
			len = lfsr_take(stim_state, 4) % 8'd13;
			gap = int'(lfsr_take(stim_state, 2));
			send_frame(addr, len);
			idle_cycles(gap);
		end
		idle_cycles(1);
		wait_drained();
		repeat (40) @(negedge clk);

		if (drained() && naks_seen > 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run("responses still pending or no frame was ever dropped");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/ice_pkg.sv
verilog/ice_bus_controller.sv
verilog/ice_bus_device.sv
verilog/ice_bus_arbiter.sv
verilog/ice_bus_top.sv
sim/tb_ice_bus.sv
